// ==== source/issue_pkg.sv ====
package issue_pkg;

    // ======================================================================
    // widths
    // ======================================================================
    localparam int XLEN   = 32;
    // 128 physical registers
    localparam int TAG_W  = 7;
    localparam int ROB_W  = 6;
    localparam int FUNC_W = 4;

    // ======================================================================
    // encodings
    // ======================================================================
    typedef enum logic [1:0] {
        FU_ALU,
        FU_MUL,
        FU_LOAD,
        FU_BRANCH
    } fu_type_e;

    typedef enum logic [1:0] {
        OPA_IS_RS1,
        OPA_IS_NPC,
        OPA_IS_PC,
        OPA_IS_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_IS_RS2,
        OPB_IS_I_IMM,
        OPB_IS_S_IMM,
        OPB_IS_B_IMM,
        OPB_IS_U_IMM,
        OPB_IS_J_IMM
    } opb_sel_e;

    // ======================================================================
    // packets
    // ======================================================================
    // one decoded and renamed instruction from dispatch
    typedef struct packed {
        logic [XLEN-1:0]   inst;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   npc;
        logic [FUNC_W-1:0] alu_func;
        fu_type_e          fu_type;
        opa_sel_e          opa_select;
        opb_sel_e          opb_select;
        logic              wr_mem;
        logic [ROB_W-1:0]  rob_idx;
        logic [TAG_W-1:0]  dest_tag;
        // source operands, value only meaningful once ready
        logic [TAG_W-1:0]  src1_tag;
        logic              src1_ready;
        logic [XLEN-1:0]   src1_value;
        logic [TAG_W-1:0]  src2_tag;
        logic              src2_ready;
        logic [XLEN-1:0]   src2_value;
    } disp_packet_t;

    // one reservation station slot
    typedef struct packed {
        logic         valid;
        disp_packet_t packet;
    } rs_entry_t;

    // request to a function unit
    typedef struct packed {
        logic              valid;
        logic [FUNC_W-1:0] opcode;
        logic [XLEN-1:0]   src1_val;
        logic [XLEN-1:0]   src2_val;
        logic [XLEN-1:0]   imm;
        logic              src2_valid;
        logic [ROB_W-1:0]  rob_idx;
        logic [TAG_W-1:0]  dest_tag;
        fu_type_e          fu_type;
        logic              wr_mem;
    } issue_packet_t;

endpackage

// ==== source/rs_if.sv ====
`timescale 1ns/10ps

interface rs_if #(
    parameter int unsigned RS_DEPTH = 8
);
    import issue_pkg::*;

    // slot contents as seen by selector and issue logic
    rs_entry_t [RS_DEPTH-1:0] entries;
    // valid and both sources ready
    logic      [RS_DEPTH-1:0] ready;
    // one-hot or zero, slot leaving this cycle
    logic      [RS_DEPTH-1:0] grant;

    modport station (
        output entries,
        output ready,
        input  grant
    );

    modport selector (
        input  entries,
        input  ready,
        output grant
    );

    modport issue (
        input  entries,
        input  grant
    );

endinterface

// ==== source/reservation_station.sv ====
`timescale 1ns/10ps

module reservation_station #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    // dispatch side
    input  logic                         dispatch_valid_i,
    input  issue_pkg::disp_packet_t      dispatch_i,
    output logic                         dispatch_ready_o,
    // common data bus
    input  logic                         cdb_valid_i,
    input  logic [issue_pkg::TAG_W-1:0]  cdb_tag_i,
    input  logic [issue_pkg::XLEN-1:0]   cdb_value_i,
    // towards selector and issue logic
    rs_if.station                        rs
);
    import issue_pkg::*;

    // slot state
    logic         [RS_DEPTH-1:0] valid_q;
    disp_packet_t                pkt_q [RS_DEPTH];

    logic [RS_DEPTH-1:0] alloc_oh;
    logic                dispatch_fire;

    // capture a broadcast value into any source still waiting on its tag
    function automatic disp_packet_t wake(
        input disp_packet_t     pkt,
        input logic             bus_valid,
        input logic [TAG_W-1:0] bus_tag,
        input logic [XLEN-1:0]  bus_value
    );
        disp_packet_t res;
        res = pkt;
        if (bus_valid && !pkt.src1_ready && pkt.src1_tag == bus_tag) begin
            res.src1_ready = 1'b1;
            res.src1_value = bus_value;
        end
        if (bus_valid && !pkt.src2_ready && pkt.src2_tag == bus_tag) begin
            res.src2_ready = 1'b1;
            res.src2_value = bus_value;
        end
        return res;
    endfunction

    // ======================================================================
    // allocation
    // ======================================================================
    // lowest free slot, one-hot, zero when full
    always_comb begin : find_free
        alloc_oh = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_oh = '0;
                alloc_oh[i] = 1'b1;
            end
        end
    end

    // slot freed by a grant this cycle is not offered until next cycle
    assign dispatch_ready_o = ~&valid_q;
    assign dispatch_fire    = dispatch_valid_i & dispatch_ready_o;

    // ======================================================================
    // slot state update
    // ======================================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (dispatch_fire && alloc_oh[i]) begin
                    valid_q[i] <= 1'b1;
                end else if (rs.grant[i]) begin
                    valid_q[i] <= 1'b0;
                end
            end
        end
    end

    // payload, incoming packet also sees the bus in the same cycle
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (dispatch_fire && alloc_oh[i]) begin
                pkt_q[i] <= wake(dispatch_i, cdb_valid_i, cdb_tag_i, cdb_value_i);
            end else begin
                pkt_q[i] <= wake(pkt_q[i], cdb_valid_i, cdb_tag_i, cdb_value_i);
            end
        end
    end

    // ======================================================================
    // outputs to the selector
    // ======================================================================
    always_comb begin : drive_bus
        for (int i = 0; i < RS_DEPTH; i++) begin
            rs.entries[i].valid  = valid_q[i];
            rs.entries[i].packet = pkt_q[i];
            // registered readiness only, woken entry waits one cycle
            rs.ready[i] = valid_q[i] & pkt_q[i].src1_ready & pkt_q[i].src2_ready;
        end
    end

endmodule

// ==== source/issue_selector.sv ====
`timescale 1ns/10ps

module issue_selector #(
    parameter int unsigned RS_DEPTH = 8
) (
    // unit readiness straight from the top ports
    input  logic    alu_ready_i,
    input  logic    mul_ready_i,
    input  logic    load_ready_i,
    input  logic    br_ready_i,
    rs_if.selector  rs
);
    import issue_pkg::*;

    // per-slot readiness of the target unit
    logic [RS_DEPTH-1:0] unit_ok;
    // ready entries whose unit can take them
    logic [RS_DEPTH-1:0] eligible;

    // ======================================================================
    // unit mask
    // ======================================================================
    always_comb begin : unit_mask
        for (int i = 0; i < RS_DEPTH; i++) begin
            case (rs.entries[i].packet.fu_type)
                FU_ALU:    unit_ok[i] = alu_ready_i;
                FU_MUL:    unit_ok[i] = mul_ready_i;
                FU_LOAD:   unit_ok[i] = load_ready_i;
                FU_BRANCH: unit_ok[i] = br_ready_i;
                default:   unit_ok[i] = 1'b0;
            endcase
        end
    end

    // back-pressured unit's entries drop out, others may pass them
    assign eligible = rs.ready & unit_ok;

    // ======================================================================
    // fixed priority pick
    // ======================================================================
    // isolate lowest set bit, slot 0 wins
    assign rs.grant = eligible & (~eligible + RS_DEPTH'(1));

endmodule

// ==== source/issue_logic.sv ====
`timescale 1ns/10ps

module issue_logic #(
    parameter int unsigned RS_DEPTH = 8
) (
    rs_if.issue                      rs,
    // one request port per unit
    output issue_pkg::issue_packet_t alu_req_o,
    output issue_pkg::issue_packet_t mul_req_o,
    output issue_pkg::issue_packet_t load_req_o,
    output issue_pkg::issue_packet_t br_req_o
);
    import issue_pkg::*;

    disp_packet_t    sel_pkt;
    logic            granted;
    logic [XLEN-1:0] opa_val;
    logic [XLEN-1:0] opb_val;
    logic [XLEN-1:0] imm_val;
    issue_packet_t   req;

    // decoded immediates, all sign extended
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] j_imm;

    // ======================================================================
    // granted entry
    // ======================================================================
    // grant is one-hot so a plain scan is enough
    always_comb begin : pick_entry
        sel_pkt = '0;
        granted = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (rs.grant[i]) begin
                sel_pkt = rs.entries[i].packet;
                granted = 1'b1;
            end
        end
    end

    // ======================================================================
    // operand formation
    // ======================================================================
    assign i_imm = {{20{sel_pkt.inst[31]}}, sel_pkt.inst[31:20]};
    assign s_imm = {{20{sel_pkt.inst[31]}}, sel_pkt.inst[31:25], sel_pkt.inst[11:7]};
    assign b_imm = {{19{sel_pkt.inst[31]}}, sel_pkt.inst[31], sel_pkt.inst[7],
                    sel_pkt.inst[30:25], sel_pkt.inst[11:8], 1'b0};
    assign u_imm = {sel_pkt.inst[31:12], 12'b0};
    assign j_imm = {{11{sel_pkt.inst[31]}}, sel_pkt.inst[31], sel_pkt.inst[19:12],
                    sel_pkt.inst[20], sel_pkt.inst[30:21], 1'b0};

    always_comb begin : operand_a
        case (sel_pkt.opa_select)
            OPA_IS_RS1:  opa_val = sel_pkt.src1_value;
            OPA_IS_NPC:  opa_val = sel_pkt.npc;
            OPA_IS_PC:   opa_val = sel_pkt.pc;
            default:     opa_val = '0;
        endcase
    end

    // imm stays zero for register-register ops
    always_comb begin : operand_b
        imm_val = '0;
        case (sel_pkt.opb_select)
            OPB_IS_I_IMM: imm_val = i_imm;
            OPB_IS_S_IMM: imm_val = s_imm;
            OPB_IS_B_IMM: imm_val = b_imm;
            OPB_IS_U_IMM: imm_val = u_imm;
            OPB_IS_J_IMM: imm_val = j_imm;
            default:      imm_val = '0;
        endcase
        opb_val = (sel_pkt.opb_select == OPB_IS_RS2) ? sel_pkt.src2_value : imm_val;
    end

    // ======================================================================
    // request build and routing
    // ======================================================================
    always_comb begin : route
        req            = '0;
        req.valid      = granted;
        req.opcode     = sel_pkt.alu_func;
        req.src1_val   = opa_val;
        req.src2_val   = opb_val;
        req.imm        = imm_val;
        // stores still need rs2 as write data
        req.src2_valid = (sel_pkt.opb_select == OPB_IS_RS2) | sel_pkt.wr_mem;
        req.rob_idx    = sel_pkt.rob_idx;
        req.dest_tag   = sel_pkt.dest_tag;
        req.fu_type    = sel_pkt.fu_type;
        req.wr_mem     = sel_pkt.wr_mem;

        alu_req_o  = '0;
        mul_req_o  = '0;
        load_req_o = '0;
        br_req_o   = '0;
        case (sel_pkt.fu_type)
            FU_ALU:    alu_req_o  = req;
            FU_MUL:    mul_req_o  = req;
            FU_LOAD:   load_req_o = req;
            FU_BRANCH: br_req_o   = req;
            default:   alu_req_o  = '0;
        endcase
    end

endmodule

// ==== source/issue_top.sv ====
`timescale 1ns/10ps

module issue_top #(
    parameter int unsigned RS_DEPTH = 8
) (
    input  logic                         clock,
    input  logic                         reset,
    // dispatch, valid/ready
    input  logic                         dispatch_valid_i,
    input  issue_pkg::disp_packet_t      dispatch_i,
    output logic                         dispatch_ready_o,
    // common data bus broadcast
    input  logic                         cdb_valid_i,
    input  logic [issue_pkg::TAG_W-1:0]  cdb_tag_i,
    input  logic [issue_pkg::XLEN-1:0]   cdb_value_i,
    // unit readiness
    input  logic                         alu_ready_i,
    input  logic                         mul_ready_i,
    input  logic                         load_ready_i,
    input  logic                         br_ready_i,
    // unit requests
    output issue_pkg::issue_packet_t     alu_req_o,
    output issue_pkg::issue_packet_t     mul_req_o,
    output issue_pkg::issue_packet_t     load_req_o,
    output issue_pkg::issue_packet_t     br_req_o
);

    // ======================================================================
    // station -> selector -> issue logic
    // ======================================================================
    rs_if #(.RS_DEPTH(RS_DEPTH)) rs_bus ();

    reservation_station #(.RS_DEPTH(RS_DEPTH)) i_station (
        .clock            (clock),
        .reset            (reset),
        .dispatch_valid_i (dispatch_valid_i),
        .dispatch_i       (dispatch_i),
        .dispatch_ready_o (dispatch_ready_o),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_tag_i        (cdb_tag_i),
        .cdb_value_i      (cdb_value_i),
        .rs               (rs_bus.station)
    );

    // combinational pick, grant fed back to the station
    issue_selector #(.RS_DEPTH(RS_DEPTH)) i_selector (
        .alu_ready_i  (alu_ready_i),
        .mul_ready_i  (mul_ready_i),
        .load_ready_i (load_ready_i),
        .br_ready_i   (br_ready_i),
        .rs           (rs_bus.selector)
    );

    issue_logic #(.RS_DEPTH(RS_DEPTH)) i_issue (
        .rs         (rs_bus.issue),
        .alu_req_o  (alu_req_o),
        .mul_req_o  (mul_req_o),
        .load_req_o (load_req_o),
        .br_req_o   (br_req_o)
    );

endmodule

// ==== tests/issue_model.svh ====
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// ======================================================================
// reference copy of the station slots
// ======================================================================
logic         m_valid [RS_DEPTH];
disp_packet_t m_pkt   [RS_DEPTH];

function automatic int model_used();
    int n;
    n = 0;
    for (int i = 0; i < RS_DEPTH; i++) begin
        if (m_valid[i]) n++;
    end
    return n;
endfunction

function automatic logic model_unit_ready(fu_type_e fu, logic a, logic m, logic l, logic b);
    case (fu)
        FU_ALU:  return a;
        FU_MUL:  return m;
        FU_LOAD: return l;
        default: return b;
    endcase
endfunction

// first slot with both sources in and a free unit, -1 if none
function automatic int model_pick(logic a, logic m, logic l, logic b);
    for (int i = 0; i < RS_DEPTH; i++) begin
        if (m_valid[i] && m_pkt[i].src1_ready && m_pkt[i].src2_ready &&
            model_unit_ready(m_pkt[i].fu_type, a, m, l, b)) begin
            return i;
        end
    end
    return -1;
endfunction

// rv32 immediates, built left aligned then arithmetic shifted down
function automatic logic [XLEN-1:0] model_imm(logic [31:0] inst, opb_sel_e sel);
    logic [31:0] raw;
    case (sel)
        OPB_IS_I_IMM: return $signed(inst) >>> 20;
        OPB_IS_S_IMM: raw = {inst[31:25], inst[11:7], 20'b0};
        OPB_IS_B_IMM: raw = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0, 19'b0};
        OPB_IS_U_IMM: return {inst[31:12], 12'b0};
        OPB_IS_J_IMM: raw = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0, 11'b0};
        default:      return '0;
    endcase
    if (sel == OPB_IS_S_IMM) return $signed(raw) >>> 20;
    if (sel == OPB_IS_B_IMM) return $signed(raw) >>> 19;
    return $signed(raw) >>> 11;
endfunction

function automatic issue_packet_t model_request(disp_packet_t p);
    issue_packet_t r;
    r          = '0;
    r.valid    = 1'b1;
    r.opcode   = p.alu_func;
    case (p.opa_select)
        OPA_IS_RS1: r.src1_val = p.src1_value;
        OPA_IS_NPC: r.src1_val = p.npc;
        OPA_IS_PC:  r.src1_val = p.pc;
        default:    r.src1_val = '0;
    endcase
    r.imm        = model_imm(p.inst, p.opb_select);
    r.src2_val   = (p.opb_select == OPB_IS_RS2) ? p.src2_value : r.imm;
    r.src2_valid = (p.opb_select == OPB_IS_RS2) || p.wr_mem;
    r.rob_idx    = p.rob_idx;
    r.dest_tag   = p.dest_tag;
    r.fu_type    = p.fu_type;
    r.wr_mem     = p.wr_mem;
    return r;
endfunction

function automatic disp_packet_t model_wake(disp_packet_t p, logic v, logic [TAG_W-1:0] t,
                                            logic [XLEN-1:0] val);
    if (v && !p.src1_ready && p.src1_tag == t) begin
        p.src1_ready = 1'b1;
        p.src1_value = val;
    end
    if (v && !p.src2_ready && p.src2_tag == t) begin
        p.src2_ready = 1'b1;
        p.src2_value = val;
    end
    return p;
endfunction

// state after the coming edge
task automatic model_step(input logic dv, input disp_packet_t dp, input logic cv,
                          input logic [TAG_W-1:0] ct, input logic [XLEN-1:0] cval,
                          input int pick);
    int slot;
    slot = -1;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
        if (!m_valid[i]) slot = i;
    end
    for (int i = 0; i < RS_DEPTH; i++) begin
        m_pkt[i] = model_wake(m_pkt[i], cv, ct, cval);
    end
    if (pick >= 0) m_valid[pick] = 1'b0;
    // incoming packet sees the same broadcast
    if (dv && slot >= 0) begin
        m_valid[slot] = 1'b1;
        m_pkt[slot]   = model_wake(dp, cv, ct, cval);
    end
endtask

`endif

// ==== tests/issue_tb.sv ====
`timescale 1ns/10ps

module issue_tb;
    import issue_pkg::*;

    localparam int RS_DEPTH   = 8;
    localparam int RUN_CYCLES = 2000;
    localparam int DRAIN_MAX  = 400;

    logic             clock;
    logic             reset;
    logic             dispatch_valid;
    disp_packet_t     dispatch_pkt;
    logic             dispatch_ready;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [XLEN-1:0]  cdb_value;
    logic             alu_ready;
    logic             mul_ready;
    logic             load_ready;
    logic             br_ready;
    issue_packet_t    alu_req;
    issue_packet_t    mul_req;
    issue_packet_t    load_req;
    issue_packet_t    br_req;

    integer seed;
    int     req_errors;
    int     rdy_errors;
    int     other_errors;
    int     next_id;
    int     drain_cycles;
    // per rob index, dispatched but not yet seen on a request port
    int     outstanding [64];
    bit     dispatch_held;

    `include "issue_model.svh"

    issue_top #(.RS_DEPTH(RS_DEPTH)) i_dut (
        .clock (clock), .reset (reset),
        .dispatch_valid_i (dispatch_valid), .dispatch_i (dispatch_pkt),
        .dispatch_ready_o (dispatch_ready),
        .cdb_valid_i (cdb_valid), .cdb_tag_i (cdb_tag), .cdb_value_i (cdb_value),
        .alu_ready_i (alu_ready), .mul_ready_i (mul_ready),
        .load_ready_i (load_ready), .br_ready_i (br_ready),
        .alu_req_o (alu_req), .mul_req_o (mul_req),
        .load_req_o (load_req), .br_req_o (br_req)
    );

    always #5 clock = ~clock;

    // ======================================================================
    // compare tasks
    // ======================================================================
    // idle ports only need valid low, the rest is don't care
    task automatic check_request(input string name, input issue_packet_t exp,
                                 input issue_packet_t act);
        if ((exp.valid && act !== exp) || (!exp.valid && act.valid !== 1'b0)) begin
            req_errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_ready(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            rdy_errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // one accepted request retires one outstanding dispatch
    task automatic note_issue(input string name, input issue_packet_t req, input logic rdy);
        if (req.valid === 1'b1) begin
            if (!rdy) begin
                other_errors++;
                $display("%s request raised while that unit is stalled", name);
            end else if (outstanding[req.rob_idx] == 0) begin
                other_errors++;
                $display("%s issued rob index %0d with nothing outstanding", name, req.rob_idx);
            end else begin
                outstanding[req.rob_idx]--;
            end
        end
    endtask

    // ======================================================================
    // stimulus
    // ======================================================================
    task automatic make_packet(output disp_packet_t p);
        p.inst       = $random(seed);
        p.pc         = $random(seed) & 32'hffff_fffc;
        p.npc        = p.pc + 4;
        p.alu_func   = FUNC_W'($random(seed));
        p.fu_type    = fu_type_e'(2'($random(seed)));
        p.opa_select = opa_sel_e'(2'($random(seed)));
        p.opb_select = opb_sel_e'(3'($unsigned($random(seed)) % 6));
        p.wr_mem     = (p.fu_type == FU_LOAD) && (($random(seed) & 1) != 0);
        p.rob_idx    = ROB_W'(next_id);
        p.dest_tag   = TAG_W'($random(seed));
        // small tag range so one broadcast wakes several sources
        p.src1_tag   = TAG_W'($random(seed) & 15);
        p.src1_ready = ($random(seed) & 1) != 0;
        p.src1_value = $random(seed);
        p.src2_tag   = TAG_W'($random(seed) & 15);
        p.src2_ready = ($random(seed) & 1) != 0;
        p.src2_value = $random(seed);
    endtask

    task automatic drive_inputs(input bit draining, input int cycle);
        logic [TAG_W-1:0] pending [$];
        bit               quiet;
        // quiet phases let the station fill up
        quiet = ((cycle / 250) % 2) == 1;
        if (draining) begin
            dispatch_valid = 1'b0;
            {alu_ready, mul_ready, load_ready, br_ready} = 4'hf;
        end else begin
            if (!dispatch_held) begin
                make_packet(dispatch_pkt);
                dispatch_valid = ($random(seed) & 3) != 0;
            end
            alu_ready  = ($random(seed) & 3) != 0;
            mul_ready  = ($random(seed) & 3) != 0;
            load_ready = ($random(seed) & 3) != 0;
            br_ready   = ($random(seed) & 3) != 0;
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (m_valid[i] && !m_pkt[i].src1_ready) pending.push_back(m_pkt[i].src1_tag);
            if (m_valid[i] && !m_pkt[i].src2_ready) pending.push_back(m_pkt[i].src2_tag);
        end
        // incoming tags too, for the same cycle bypass
        if (dispatch_valid && !dispatch_pkt.src1_ready) pending.push_back(dispatch_pkt.src1_tag);
        if (dispatch_valid && !dispatch_pkt.src2_ready) pending.push_back(dispatch_pkt.src2_tag);
        cdb_valid = 1'b0;
        if (pending.size() > 0 &&
            (draining || ($random(seed) & (quiet ? 7 : 1)) == 0)) begin
            cdb_valid = 1'b1;
            cdb_tag   = pending[$unsigned($random(seed)) % pending.size()];
            cdb_value = $random(seed);
        end
    endtask

    // ======================================================================
    // per-cycle check, then advance the model
    // ======================================================================
    task automatic check_cycle();
        int            pick;
        logic          accept;
        issue_packet_t exp [4];
        for (int k = 0; k < 4; k++) exp[k] = '0;
        pick = model_pick(alu_ready, mul_ready, load_ready, br_ready);
        if (pick >= 0) exp[m_pkt[pick].fu_type] = model_request(m_pkt[pick]);
        check_request("alu request", exp[FU_ALU], alu_req);
        check_request("mul request", exp[FU_MUL], mul_req);
        check_request("load request", exp[FU_LOAD], load_req);
        check_request("branch request", exp[FU_BRANCH], br_req);
        check_ready("dispatch ready", model_used() < RS_DEPTH, dispatch_ready);
        accept = dispatch_valid && model_used() < RS_DEPTH;
        if (accept) begin
            outstanding[dispatch_pkt.rob_idx]++;
            next_id++;
        end
        // hold the packet until the station takes it
        dispatch_held = dispatch_valid && !accept;
        note_issue("alu", alu_req, alu_ready);
        note_issue("mul", mul_req, mul_ready);
        note_issue("load", load_req, load_ready);
        note_issue("branch", br_req, br_ready);
        model_step(dispatch_valid, dispatch_pkt, cdb_valid, cdb_tag, cdb_value, pick);
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        seed = 32'hef7aab71;
        clock = 1'b0;
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_pkt = '0;
        cdb_valid = 1'b0;
        cdb_tag = '0;
        cdb_value = '0;
        {alu_ready, mul_ready, load_ready, br_ready} = 4'h0;
        req_errors = 0;
        rdy_errors = 0;
        other_errors = 0;
        next_id = 0;
        dispatch_held = 1'b0;
        for (int i = 0; i < 64; i++) outstanding[i] = 0;
        for (int i = 0; i < RS_DEPTH; i++) m_valid[i] = 1'b0;

        repeat (8) @(posedge clock);
        #1 reset = 1'b0;
        // empty station right out of reset
        check_request("reset alu", '0, alu_req);
        check_request("reset mul", '0, mul_req);
        check_request("reset load", '0, load_req);
        check_request("reset branch", '0, br_req);
        check_ready("reset dispatch ready", 1'b1, dispatch_ready);

        for (int c = 0; c < RUN_CYCLES; c++) begin
            drive_inputs(1'b0, c);
            #4 check_cycle();
            @(posedge clock);
            #1;
        end

        // drain with every unit open
        drain_cycles = 0;
        while (model_used() != 0 && drain_cycles < DRAIN_MAX) begin
            drive_inputs(1'b1, 0);
            #4 check_cycle();
            @(posedge clock);
            #1;
            drain_cycles++;
        end
        if (model_used() != 0) begin
            other_errors++;
            $display("drain timed out with %0d entries left in the station", model_used());
        end
        for (int i = 0; i < 64; i++) begin
            if (outstanding[i] != 0) begin
                other_errors++;
                $display("rob index %0d dispatched but never issued", i);
            end
        end

        $display("dispatched %0d, errors: request %0d, ready %0d, other %0d",
                 next_id, req_errors, rdy_errors, other_errors);
        if (req_errors + rdy_errors + other_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+tests
source/issue_pkg.sv
source/rs_if.sv
source/reservation_station.sv
source/issue_selector.sv
source/issue_logic.sv
source/issue_top.sv
tests/issue_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary
TOP      := issue_tb
FILELIST := compile.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(wildcard source/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
